/* design/input_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "packet_switch_consts.svh"

module input_queue
    import packet_switch_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  axis_word_t s_tdata,
    input  logic       s_tlast,
    input  logic       s_tvalid,
    output logic       s_tready,
    queue_if.queue     q
);

    localparam int META_PAD_W = 32 - `PS_LEN_W - `PS_PORT_W;

    rx_state_t            rx_state;
    port_sel_t            dest_q;
    pkt_len_t             len_q;
    port_sel_t            pkt_dest;
    pkt_len_t             pkt_len;
    meta_word_t           meta_push_data;
    logic                 accept;
    logic                 meta_push;
    logic                 byte_full;
    logic                 byte_empty;
    logic                 byte_pop;
    logic [`PS_BYTE_W:0]  byte_pop_data;
    logic                 meta_full;
    logic                 meta_empty;
    logic                 meta_pop;

    // ----------------------------------------------------------------------
    // Receive side
    // ----------------------------------------------------------------------

    // Stall while either buffer has no room
    assign s_tready  = !byte_full && !meta_full;
    assign accept    = s_tvalid && s_tready;
    assign meta_push = accept && s_tlast;

    // Header byte supplies the destination, also for one-byte packets
    assign pkt_dest = (rx_state == RX_HEADER) ? s_tdata[`PS_PORT_W-1:0] : dest_q;
    assign pkt_len  = (rx_state == RX_HEADER) ? pkt_len_t'(1) : len_q + 1'b1;

    assign meta_push_data = {pkt_len, {META_PAD_W{1'b0}}, pkt_dest};

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rx_state <= RX_HEADER;
            len_q    <= '0;
        end
        else if (accept)
        begin
            len_q    <= pkt_len;
            rx_state <= s_tlast ? RX_HEADER : RX_BODY;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dest_q <= pkt_dest;
        end
    end

    // ----------------------------------------------------------------------
    // Buffers
    // ----------------------------------------------------------------------

    // Byte plus last flag
    sync_fifo #(
        .WIDTH(`PS_BYTE_W + 1),
        .DEPTH(`PS_BUF_DEPTH)
    ) u_byte_fifo (
        .clk(clk),
        .resetn(resetn),
        .push(accept),
        .push_data({s_tlast, s_tdata[`PS_BYTE_W-1:0]}),
        .full(byte_full),
        .pop(byte_pop),
        .pop_data(byte_pop_data),
        .empty(byte_empty)
    );

    // Entry only appears once the whole packet is stored
    sync_fifo #(
        .WIDTH(32),
        .DEPTH(`PS_META_DEPTH)
    ) u_meta_fifo (
        .clk(clk),
        .resetn(resetn),
        .push(meta_push),
        .push_data(meta_push_data),
        .full(meta_full),
        .pop(meta_pop),
        .pop_data(q.meta_data),
        .empty(meta_empty)
    );

    assign byte_pop     = !byte_empty && q.buf_ready;
    assign meta_pop     = !meta_empty && q.meta_ready;
    assign q.buf_valid  = !byte_empty;
    assign q.buf_data   = byte_pop_data[`PS_BYTE_W-1:0];
    assign q.buf_last   = byte_pop_data[`PS_BYTE_W];
    assign q.meta_valid = !meta_empty;

    // Longer packets would not fit the byte buffer
    a_pkt_len_max: assert property (@(posedge clk) disable iff (!resetn)
        accept |-> pkt_len <= `PS_BUF_DEPTH);

endmodule

`default_nettype wire

/* design/packet_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "packet_switch_consts.svh"

module packet_arbiter
    import packet_switch_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    queue_if.arbiter   qa,
    queue_if.arbiter   qb,
    queue_if.arbiter   qc,
    output axis_word_t m_a_tdata,
    output logic       m_a_tlast,
    output logic       m_a_tvalid,
    input  logic       m_a_tready,
    output axis_word_t m_b_tdata,
    output logic       m_b_tlast,
    output logic       m_b_tvalid,
    input  logic       m_b_tready,
    output axis_word_t m_c_tdata,
    output logic       m_c_tlast,
    output logic       m_c_tvalid,
    input  logic       m_c_tready
);

    localparam int NP    = `PS_NUM_PORTS;
    // Outputs a, b, c and the drain path as owner 3
    localparam int NO    = `PS_NUM_PORTS + 1;
    localparam int PAD_W = `PS_AXIS_DATA_W - `PS_BYTE_W;

    logic [NP-1:0] in_meta_valid;
    logic [NP-1:0] in_buf_valid;
    logic [NP-1:0] in_buf_last;
    logic [NP-1:0] in_buf_ready;
    logic [NP-1:0] in_meta_ready;
    port_sel_t     head_dest [NP];
    byte_t         in_buf_data [NP];

    arb_state_t    state [NO];
    port_sel_t     sel [NO];
    port_sel_t     rr_ptr [NO];
    logic [NO-1:0] owner_ready;
    logic [NO-1:0] grant_valid;
    port_sel_t     grant_idx [NO];
    logic [NO-1:0] done;
    logic [NO-1:0] owned_by [NP];

    logic [NP-1:0] out_valid;
    logic [NP-1:0] out_last;
    axis_word_t    out_data [NP];

    // ----------------------------------------------------------------------
    // Queue side gathered into arrays
    // ----------------------------------------------------------------------
    assign in_meta_valid  = {qc.meta_valid, qb.meta_valid, qa.meta_valid};
    assign in_buf_valid   = {qc.buf_valid, qb.buf_valid, qa.buf_valid};
    assign in_buf_last    = {qc.buf_last, qb.buf_last, qa.buf_last};
    assign head_dest[0]   = qa.meta_data[`PS_PORT_W-1:0];
    assign head_dest[1]   = qb.meta_data[`PS_PORT_W-1:0];
    assign head_dest[2]   = qc.meta_data[`PS_PORT_W-1:0];
    assign in_buf_data[0] = qa.buf_data;
    assign in_buf_data[1] = qb.buf_data;
    assign in_buf_data[2] = qc.buf_data;

    assign qa.buf_ready  = in_buf_ready[0];
    assign qb.buf_ready  = in_buf_ready[1];
    assign qc.buf_ready  = in_buf_ready[2];
    // Metadata leaves together with the last byte
    assign in_meta_ready = in_buf_ready & in_buf_valid & in_buf_last;
    assign qa.meta_ready = in_meta_ready[0];
    assign qb.meta_ready = in_meta_ready[1];
    assign qc.meta_ready = in_meta_ready[2];

    // Drain accepts a byte every cycle
    assign owner_ready = {1'b1, m_c_tready, m_b_tready, m_a_tready};

    // ----------------------------------------------------------------------
    // Round-robin pick, starting at each owner's pointer
    // ----------------------------------------------------------------------
    always_comb
    begin
        int idx;
        for (int o = 0; o < NO; o++)
        begin
            grant_valid[o] = 1'b0;
            grant_idx[o]   = '0;
            for (int k = 0; k < NP; k++)
            begin
                idx = int'(rr_ptr[o]) + k;
                if (idx >= NP)
                begin
                    idx = idx - NP;
                end
                if (!grant_valid[o] && in_meta_valid[idx] &&
                    head_dest[idx] == port_sel_t'(o))
                begin
                    grant_valid[o] = 1'b1;
                    grant_idx[o]   = port_sel_t'(idx);
                end
            end
        end
    end

    // Byte readies follow whichever owner holds each input
    always_comb
    begin
        in_buf_ready = '0;
        for (int i = 0; i < NP; i++)
        begin
            owned_by[i] = '0;
        end
        for (int o = 0; o < NO; o++)
        begin
            done[o] = 1'b0;
            if (state[o] != ARB_IDLE)
            begin
                owned_by[sel[o]][o] = 1'b1;
                if (owner_ready[o])
                begin
                    in_buf_ready[sel[o]] = 1'b1;
                end
                done[o] = owner_ready[o] && in_buf_valid[sel[o]] && in_buf_last[sel[o]];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            for (int o = 0; o < NO; o++)
            begin
                state[o]  <= ARB_IDLE;
                sel[o]    <= '0;
                rr_ptr[o] <= '0;
            end
        end
        else
        begin
            for (int o = 0; o < NO; o++)
            begin
                case (state[o])
                    ARB_IDLE:
                        if (grant_valid[o])
                        begin
                            state[o]  <= (o == `PS_DROP_DEST) ? ARB_DROP : ARB_SEND;
                            sel[o]    <= grant_idx[o];
                            rr_ptr[o] <= (grant_idx[o] == NP - 1) ? '0 : grant_idx[o] + 1'b1;
                        end
                    default:
                        if (done[o])
                        begin
                            state[o] <= ARB_IDLE;
                        end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // Crossbar to the outputs, bytes zero-extended
    // ----------------------------------------------------------------------
    always_comb
    begin
        for (int o = 0; o < NP; o++)
        begin
            out_valid[o] = (state[o] == ARB_SEND) && in_buf_valid[sel[o]];
            out_last[o]  = in_buf_last[sel[o]];
            out_data[o]  = {{PAD_W{1'b0}}, in_buf_data[sel[o]]};
        end
    end

    assign m_a_tdata  = out_data[0];
    assign m_a_tlast  = out_last[0];
    assign m_a_tvalid = out_valid[0];
    assign m_b_tdata  = out_data[1];
    assign m_b_tlast  = out_last[1];
    assign m_b_tvalid = out_valid[1];
    assign m_c_tdata  = out_data[2];
    assign m_c_tlast  = out_last[2];
    assign m_c_tvalid = out_valid[2];

    // An input feeds at most one output or the drain
    for (genvar i = 0; i < NP; i++)
    begin : g_owner_chk
        a_single_owner: assert property (@(posedge clk) disable iff (!resetn)
            $onehot0(owned_by[i]));
    end

endmodule

`default_nettype wire

/* design/packet_switch_consts.svh */
`ifndef PACKET_SWITCH_CONSTS_SVH
`define PACKET_SWITCH_CONSTS_SVH

// ----------------------------------------------------------------------
// Switch geometry
// ----------------------------------------------------------------------
`define PS_NUM_PORTS    3
`define PS_AXIS_DATA_W  32
`define PS_BYTE_W       8
`define PS_PORT_W       2
`define PS_LEN_W        16

// Input buffering, one full packet of the largest size fits
`define PS_BUF_DEPTH    64
`define PS_META_DEPTH   4

// Destination code for packets that are thrown away
`define PS_DROP_DEST    3

`endif

/* design/packet_switch_pkg.sv */
`default_nettype none

`include "packet_switch_consts.svh"

package packet_switch_pkg;

    // Stream and buffer words
    typedef logic [`PS_AXIS_DATA_W-1:0] axis_word_t;
    typedef logic [`PS_BYTE_W-1:0]      byte_t;
    typedef logic [`PS_PORT_W-1:0]      port_sel_t;
    typedef logic [`PS_LEN_W-1:0]       pkt_len_t;

    // Length in 31:16, destination in 1:0
    typedef logic [31:0]                meta_word_t;

    typedef enum logic {
        RX_HEADER,
        RX_BODY
    } rx_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SEND,
        ARB_DROP
    } arb_state_t;

endpackage

`default_nettype wire

/* design/packet_switch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module packet_switch_top
    import packet_switch_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Stream inputs
    input  axis_word_t pmod_a_s_tdata,
    input  logic       pmod_a_s_tlast,
    input  logic       pmod_a_s_tvalid,
    output logic       pmod_a_s_tready,
    input  axis_word_t pmod_b_s_tdata,
    input  logic       pmod_b_s_tlast,
    input  logic       pmod_b_s_tvalid,
    output logic       pmod_b_s_tready,
    input  axis_word_t pmod_c_s_tdata,
    input  logic       pmod_c_s_tlast,
    input  logic       pmod_c_s_tvalid,
    output logic       pmod_c_s_tready,

    // Stream outputs
    output axis_word_t pmod_a_m_tdata,
    output logic       pmod_a_m_tlast,
    output logic       pmod_a_m_tvalid,
    input  logic       pmod_a_m_tready,
    output axis_word_t pmod_b_m_tdata,
    output logic       pmod_b_m_tlast,
    output logic       pmod_b_m_tvalid,
    input  logic       pmod_b_m_tready,
    output axis_word_t pmod_c_m_tdata,
    output logic       pmod_c_m_tlast,
    output logic       pmod_c_m_tvalid,
    input  logic       pmod_c_m_tready
);

    queue_if q_a ();
    queue_if q_b ();
    queue_if q_c ();

    // ----------------------------------------------------------------------
    // One store-and-forward queue per input
    // ----------------------------------------------------------------------
    input_queue u_queue_a (
        .clk(clk),
        .resetn(resetn),
        .s_tdata(pmod_a_s_tdata),
        .s_tlast(pmod_a_s_tlast),
        .s_tvalid(pmod_a_s_tvalid),
        .s_tready(pmod_a_s_tready),
        .q(q_a.queue)
    );

    input_queue u_queue_b (
        .clk(clk),
        .resetn(resetn),
        .s_tdata(pmod_b_s_tdata),
        .s_tlast(pmod_b_s_tlast),
        .s_tvalid(pmod_b_s_tvalid),
        .s_tready(pmod_b_s_tready),
        .q(q_b.queue)
    );

    input_queue u_queue_c (
        .clk(clk),
        .resetn(resetn),
        .s_tdata(pmod_c_s_tdata),
        .s_tlast(pmod_c_s_tlast),
        .s_tvalid(pmod_c_s_tvalid),
        .s_tready(pmod_c_s_tready),
        .q(q_c.queue)
    );

    // Routing and per-output arbitration
    packet_arbiter u_arbiter (
        .clk(clk),
        .resetn(resetn),
        .qa(q_a.arbiter),
        .qb(q_b.arbiter),
        .qc(q_c.arbiter),
        .m_a_tdata(pmod_a_m_tdata),
        .m_a_tlast(pmod_a_m_tlast),
        .m_a_tvalid(pmod_a_m_tvalid),
        .m_a_tready(pmod_a_m_tready),
        .m_b_tdata(pmod_b_m_tdata),
        .m_b_tlast(pmod_b_m_tlast),
        .m_b_tvalid(pmod_b_m_tvalid),
        .m_b_tready(pmod_b_m_tready),
        .m_c_tdata(pmod_c_m_tdata),
        .m_c_tlast(pmod_c_m_tlast),
        .m_c_tvalid(pmod_c_m_tvalid),
        .m_c_tready(pmod_c_m_tready)
    );

endmodule

`default_nettype wire

/* design/queue_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface queue_if
    import packet_switch_pkg::*;
();

    // Buffered bytes of complete packets
    logic       buf_valid;
    byte_t      buf_data;
    logic       buf_last;
    logic       buf_ready;

    // One entry per stored packet
    logic       meta_valid;
    meta_word_t meta_data;
    logic       meta_ready;

    modport queue (
        output buf_valid, buf_data, buf_last,
        output meta_valid, meta_data,
        input  buf_ready, meta_ready
    );

    modport arbiter (
        input  buf_valid, buf_data, buf_last,
        input  meta_valid, meta_data,
        output buf_ready, meta_ready
    );

endinterface

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    // Head word is visible without a read cycle
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Callers must respect full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) full |-> !push);
    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn) empty |-> !pop);

endmodule

`default_nettype wire

/* packet_switch.f */
+incdir+design
design/packet_switch_pkg.sv
design/queue_if.sv
design/sync_fifo.sv
design/input_queue.sv
design/packet_arbiter.sv
design/packet_switch_top.sv
test/tb_clock_gen.sv
test/packet_switch_tb.sv

/* test/packet_switch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "packet_switch_consts.svh"

module packet_switch_tb
    import packet_switch_pkg::*;
();

    localparam int NP          = `PS_NUM_PORTS;
    localparam int T2_LEN      = 6;
    localparam int T3_LEN      = 8;
    localparam int T4_LEN      = 10;
    localparam int T5_LEN      = 64;
    localparam int T6_DROP_LEN = 5;
    localparam int T6_NEXT_LEN = 4;
    localparam int TOTAL_BYTES = T2_LEN + 3 * T3_LEN + 3 * T4_LEN + 4 * T5_LEN
                               + T6_DROP_LEN + T6_NEXT_LEN;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_BYTES;

    wire           clk;
    wire           resetn;

    axis_word_t    s_tdata [NP];
    logic [NP-1:0] s_tlast;
    logic [NP-1:0] s_tvalid;
    logic [NP-1:0] m_tready;
    wire  [NP-1:0] s_tready;
    wire  [NP-1:0] m_tvalid;
    wire  [NP-1:0] m_tlast;
    wire axis_word_t m_data_a;
    wire axis_word_t m_data_b;
    wire axis_word_t m_data_c;

    // Reference model keeps one expected byte stream per output
    byte_t         exp_data [NP][$];
    logic          exp_last [NP][$];
    logic [NP-1:0] pkt_start;

    logic [31:0]   lfsr_state;
    logic [31:0]   bp_word;
    logic          bp_on;
    logic          stall_seen;
    string         cur_test;

    tb_clock_gen u_clock_gen (
        .clk(clk),
        .resetn(resetn)
    );

    packet_switch_top u_packet_switch_top (
        .clk(clk),
        .resetn(resetn),
        .pmod_a_s_tdata(s_tdata[0]),
        .pmod_a_s_tlast(s_tlast[0]),
        .pmod_a_s_tvalid(s_tvalid[0]),
        .pmod_a_s_tready(s_tready[0]),
        .pmod_b_s_tdata(s_tdata[1]),
        .pmod_b_s_tlast(s_tlast[1]),
        .pmod_b_s_tvalid(s_tvalid[1]),
        .pmod_b_s_tready(s_tready[1]),
        .pmod_c_s_tdata(s_tdata[2]),
        .pmod_c_s_tlast(s_tlast[2]),
        .pmod_c_s_tvalid(s_tvalid[2]),
        .pmod_c_s_tready(s_tready[2]),
        .pmod_a_m_tdata(m_data_a),
        .pmod_a_m_tlast(m_tlast[0]),
        .pmod_a_m_tvalid(m_tvalid[0]),
        .pmod_a_m_tready(m_tready[0]),
        .pmod_b_m_tdata(m_data_b),
        .pmod_b_m_tlast(m_tlast[1]),
        .pmod_b_m_tvalid(m_tvalid[1]),
        .pmod_b_m_tready(m_tready[1]),
        .pmod_c_m_tdata(m_data_c),
        .pmod_c_m_tlast(m_tlast[2]),
        .pmod_c_m_tvalid(m_tvalid[2]),
        .pmod_c_m_tready(m_tready[2])
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic axis_word_t out_data(input int p);
        case (p)
            0:       return m_data_a;
            1:       return m_data_b;
            default: return m_data_c;
        endcase
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input axis_word_t exp, input axis_word_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                               cur_test, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_run($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                               cur_test, what, exp, act));
        end
    endtask

    task automatic check_port(input string what, input port_sel_t exp, input port_sel_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
                               cur_test, what, exp, act));
        end
    endtask

    // Header gets the destination in its low bits and the rest is random
    task automatic make_packet(input port_sel_t dest, input int len,
                               output axis_word_t words[$]);
        axis_word_t w;
        words = {};
        for (int i = 0; i < len; i++)
        begin
            w = lfsr_bits(32);
            if (i == 0)
            begin
                w[`PS_PORT_W-1:0] = dest;
            end
            words.push_back(w);
        end
    endtask

    // Routing rule applied to byte 0 of each word
    task automatic expect_packet(input axis_word_t words[$]);
        port_sel_t dest;
        dest = port_sel_t'(words[0][`PS_PORT_W-1:0]);
        if (dest != port_sel_t'(`PS_DROP_DEST))
        begin
            for (int i = 0; i < words.size(); i++)
            begin
                exp_data[dest].push_back(words[i][`PS_BYTE_W-1:0]);
                exp_last[dest].push_back(i == words.size() - 1);
            end
        end
    endtask

    // Called 2 ns after a rising edge and returns at the same phase
    task automatic send_packet(input int p, input axis_word_t words[$]);
        for (int i = 0; i < words.size(); i++)
        begin
            s_tdata[p]  = words[i];
            s_tlast[p]  = (i == words.size() - 1);
            s_tvalid[p] = 1'b1;
            @(negedge clk);
            while (!s_tready[p])
            begin
                @(negedge clk);
            end
            @(posedge clk);
            #2;
        end
        s_tvalid[p] = 1'b0;
        s_tlast[p]  = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data[0].size() + exp_data[1].size() + exp_data[2].size() != 0)
        begin
            @(posedge clk);
        end
        // A few idle cycles so stray bytes still show up
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic take_output(input int p);
        byte_t      exp_byte;
        logic       exp_flag;
        axis_word_t act;
        act      = out_data(p);
        exp_byte = exp_data[p].pop_front();
        exp_flag = exp_last[p].pop_front();
        if (pkt_start[p])
        begin
            check_port("arrival port", port_sel_t'(p), port_sel_t'(act[`PS_PORT_W-1:0]));
        end
        check_word("output byte", axis_word_t'(exp_byte), act);
        check_flag("last flag", exp_flag, m_tlast[p]);
        pkt_start[p] = exp_flag;
    endtask

    // ----------------------------------------------------------------------
    // Output monitor and back-pressure
    // ----------------------------------------------------------------------

    // Inputs change 2 ns after the edge, so the falling edge sees settled values
    always @(negedge clk)
    begin
        if (resetn)
        begin
            for (int p = 0; p < NP; p++)
            begin
                if (m_tvalid[p] && exp_data[p].size() == 0)
                begin
                    stop_run($sformatf("Output %0d presented a byte with no packet due in %s",
                                       p, cur_test));
                end
                else if (m_tvalid[p] && m_tready[p])
                begin
                    take_output(p);
                end
                if (s_tvalid[p] && !s_tready[p])
                begin
                    stall_seen = 1'b1;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (bp_on)
        begin
            bp_word = lfsr_bits(NP);
        end
        else
        begin
            bp_word = '1;
        end
        #2;
        m_tready = bp_word[NP-1:0];
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run($sformatf("Timeout: the run did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
    end

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        cur_test = "reset state";
        for (int p = 0; p < NP; p++)
        begin
            check_flag("m_tvalid after reset", 1'b0, m_tvalid[p]);
            check_flag("s_tready after reset", 1'b1, s_tready[p]);
        end
    endtask

    task automatic test_single_packet();
        axis_word_t pk[$];
        cur_test = "single packet a to b";
        make_packet(port_sel_t'(1), T2_LEN, pk);
        expect_packet(pk);
        send_packet(0, pk);
        wait_drained();
    endtask

    // Leaves the output c pointer back at input a
    task automatic test_parallel();
        axis_word_t pa[$];
        axis_word_t pb[$];
        axis_word_t pc[$];
        cur_test = "parallel distinct outputs";
        make_packet(port_sel_t'(1), T3_LEN, pa);
        make_packet(port_sel_t'(0), T3_LEN, pb);
        make_packet(port_sel_t'(2), T3_LEN, pc);
        expect_packet(pa);
        expect_packet(pb);
        expect_packet(pc);
        fork
            send_packet(0, pa);
            send_packet(1, pb);
            send_packet(2, pc);
        join
        wait_drained();
    endtask

    task automatic test_contention();
        axis_word_t pa[$];
        axis_word_t pb[$];
        axis_word_t pc[$];
        cur_test = "contention on c";
        make_packet(port_sel_t'(2), T4_LEN, pa);
        make_packet(port_sel_t'(2), T4_LEN, pb);
        make_packet(port_sel_t'(2), T4_LEN, pc);
        expect_packet(pa);
        expect_packet(pb);
        expect_packet(pc);
        fork
            send_packet(0, pa);
            send_packet(1, pb);
            send_packet(2, pc);
        join
        wait_drained();
    endtask

    task automatic test_backpressure();
        axis_word_t pa1[$];
        axis_word_t pa2[$];
        axis_word_t pb1[$];
        axis_word_t pb2[$];
        cur_test = "random back-pressure";
        make_packet(port_sel_t'(2), T5_LEN, pa1);
        make_packet(port_sel_t'(2), T5_LEN, pa2);
        make_packet(port_sel_t'(0), T5_LEN, pb1);
        make_packet(port_sel_t'(0), T5_LEN, pb2);
        expect_packet(pa1);
        expect_packet(pa2);
        expect_packet(pb1);
        expect_packet(pb2);
        stall_seen = 1'b0;
        bp_on      = 1'b1;
        fork
            begin
                send_packet(0, pa1);
                send_packet(0, pa2);
            end
            begin
                send_packet(1, pb1);
                send_packet(1, pb2);
            end
        join
        wait_drained();
        bp_on = 1'b0;
        check_flag("s_tready stall seen", 1'b1, stall_seen);
    endtask

    task automatic test_discard();
        axis_word_t pd[$];
        axis_word_t pn[$];
        cur_test = "discard then deliver";
        make_packet(port_sel_t'(`PS_DROP_DEST), T6_DROP_LEN, pd);
        make_packet(port_sel_t'(1), T6_NEXT_LEN, pn);
        expect_packet(pd);
        expect_packet(pn);
        send_packet(0, pd);
        send_packet(0, pn);
        wait_drained();
    endtask

    initial
    begin
        for (int p = 0; p < NP; p++)
        begin
            s_tdata[p] = '0;
        end
        s_tlast    = '0;
        s_tvalid   = '0;
        m_tready   = '1;
        pkt_start  = '1;
        bp_on      = 1'b0;
        stall_seen = 1'b0;
        bp_word    = '0;
        lfsr_state = 32'h9b6a;
        cur_test   = "";

        wait (resetn);
        @(posedge clk);
        #2;

        test_reset_state();
        test_single_packet();
        test_parallel();
        test_contention();
        test_backpressure();
        test_discard();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 4
) (
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    // Release a little after the edge, like the rest of the stimulus
    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;
    end

endmodule

`default_nettype wire
